/* source/ssb_consts.svh */
/*
  sizing constants for the sparse sample buffer
  derived widths are written out by hand and must track the depths above them
  SSB_TIME_W + SSB_INDEX_W must stay equal to SSB_WORD_W
*/
`ifndef SSB_CONSTS_SVH
`define SSB_CONSTS_SVH

////////////////////
// input side
`define SSB_CHANNELS     4
`define SSB_PAR_SAMPLES  2
`define SSB_SAMPLE_W     16

////////////////////
// buffer depths per channel
`define SSB_DATA_DEPTH   64
`define SSB_TSTAMP_DEPTH 16

////////////////////
// derived widths
// channel select
`define SSB_CHAN_W       2
// sample memory address, also the stored run index
`define SSB_INDEX_W      6
// timestamp memory address
`define SSB_TSTAMP_AW    4
`define SSB_WORD_W       32
`define SSB_TIME_W       26
// counts must reach the full depth, hence one bit over the index
`define SSB_COUNT_W      7

`endif

/* source/ssb_cfg_pkg.sv */
/*
  input side types: one parallel sample word and a channel's threshold pair
  samples are unsigned, sample 0 sits in the low bits of the word
*/
`include "ssb_consts.svh"

package ssb_cfg_pkg;

  // one input word, PAR_SAMPLES samples side by side
  typedef logic [`SSB_PAR_SAMPLES-1:0][`SSB_SAMPLE_W-1:0] sample_word_t;

  // hysteresis thresholds for one channel
  // high arms the channel, low disarms it
  typedef struct packed {
    logic [`SSB_SAMPLE_W-1:0] high;
    logic [`SSB_SAMPLE_W-1:0] low;
  } threshold_t;

endpackage

/* source/ssb_stream_pkg.sv */
/*
  readout stream types
  a 32 bit stream word is a header, a timestamp or a sample word
  the consumer decodes it from its position in the stream
*/
`include "ssb_consts.svh"

package ssb_stream_pkg;

  import ssb_cfg_pkg::*;

  // section header, count is the number of words that follow
  typedef struct packed {
    logic [`SSB_CHAN_W-1:0]                               channel;
    logic                                                 is_sample_section;
    logic [`SSB_COUNT_W-1:0]                              count;
    logic [`SSB_WORD_W-`SSB_CHAN_W-1-`SSB_COUNT_W-1:0]    pad;
  } hdr_word_t;

  // index of the first sample of a run, and the capture time of that word
  typedef struct packed {
    logic [`SSB_INDEX_W-1:0] index;
    logic [`SSB_TIME_W-1:0]  stamp_time;
  } tstamp_word_t;

  typedef union packed {
    hdr_word_t    hdr;
    tstamp_word_t tstamp;
    sample_word_t samples;
  } out_word_u;

  typedef struct packed {
    out_word_u word;
    logic      last;
  } out_beat_t;

  typedef enum logic [2:0] {
    RO_IDLE,
    RO_CAPTURE,
    RO_DRAIN,
    RO_TS_HDR,
    RO_TS_DATA,
    RO_SMP_HDR,
    RO_SMP_DATA
  } ro_state_e;

endpackage

/* source/sample_discriminator.sv */
/*
  per channel hysteresis discriminator, one cycle from input word to write request
  armed and run tracking only advance while capturing and are cleared outside capture
  new thresholds apply to words from the cycle after cfg_valid
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module sample_discriminator import ssb_cfg_pkg::*; (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                capturing,
  input  logic                                cfg_valid,
  input  threshold_t   [`SSB_CHANNELS-1:0]    cfg_thresholds,
  input  logic         [`SSB_CHANNELS-1:0]    in_valid,
  input  sample_word_t [`SSB_CHANNELS-1:0]    in_data,
  input  logic         [`SSB_CHANNELS-1:0]    chan_full,
  output logic         [`SSB_CHANNELS-1:0]    wr_en,
  output sample_word_t [`SSB_CHANNELS-1:0]    wr_data,
  output logic         [`SSB_CHANNELS-1:0]    run_start
);

  localparam int CH = `SSB_CHANNELS;
  localparam int PS = `SSB_PAR_SAMPLES;

  threshold_t [CH-1:0] thresh;
  logic       [CH-1:0] armed;
  logic       [CH-1:0] prev_kept;
  logic       [CH-1:0] any_high;
  logic       [CH-1:0] all_low;
  logic       [CH-1:0] keep;

  ////////////////////
  // decision
  always_comb begin
    for (int c = 0; c < CH; c++) begin
      any_high[c] = 1'b0;
      all_low[c] = 1'b1;
      for (int s = 0; s < PS; s++) begin
        if (in_data[c][s] > thresh[c].high) any_high[c] = 1'b1;
        if (in_data[c][s] >= thresh[c].low) all_low[c] = 1'b0;
      end
      // above high always keeps, an armed channel keeps until a fully quiet word
      keep[c] = any_high[c] || (armed[c] && !all_low[c]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      thresh <= '0;
    end else if (cfg_valid) begin
      thresh <= cfg_thresholds;
    end
  end

  ////////////////////
  // hysteresis state and write requests
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= '0;
      prev_kept <= '0;
      wr_en <= '0;
      run_start <= '0;
    end else begin
      for (int c = 0; c < CH; c++) begin
        wr_en[c] <= capturing && in_valid[c] && keep[c] && !chan_full[c];
        run_start[c] <= capturing && in_valid[c] && keep[c] && !prev_kept[c] && !chan_full[c];
        if (!capturing) begin
          armed[c] <= 1'b0;
          prev_kept[c] <= 1'b0;
        end else if (in_valid[c]) begin
          prev_kept[c] <= keep[c];
          if (any_high[c]) begin
            armed[c] <= 1'b1;
          end else if (all_low[c]) begin
            armed[c] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_data <= in_data;
  end

  // a write request only follows a word seen during capture
  assert property (@(posedge clk) disable iff (reset) |wr_en |-> $past(capturing));

endmodule

/* source/capture_timer.sv */
/*
  capture time counter, wraps at 2**SSB_TIME_W
  reads 0 in the clear cycle and 1 in the cycle after, counting only while run is high
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module capture_timer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    run,
  output logic [`SSB_TIME_W-1:0]  cap_time
);

  logic [`SSB_TIME_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      // the clear cycle itself shows 0, so the register moves on to 1
      count <= `SSB_TIME_W'(1);
    end else if (run) begin
      count <= count + 1'b1;
    end
  end

  // zero during the clear cycle lines time 0 up with the first capture cycle
  assign cap_time = clear ? '0 : count;

endmodule

/* source/sample_store.sv */
/*
  per channel sample and timestamp memories, write pointers double as counts
  a channel is full when either memory is full, then all its writes are dropped
  read is synchronous: rd_data shows the addressed word one cycle later
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module sample_store import ssb_cfg_pkg::*, ssb_stream_pkg::*; (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    clear,
  input  logic         [`SSB_CHANNELS-1:0]        wr_en,
  input  sample_word_t [`SSB_CHANNELS-1:0]        wr_data,
  input  logic         [`SSB_CHANNELS-1:0]        run_start,
  input  logic         [`SSB_TIME_W-1:0]          cap_time,
  input  logic         [`SSB_CHAN_W-1:0]          rd_chan,
  input  logic                                    rd_is_tstamp,
  input  logic         [`SSB_INDEX_W-1:0]         rd_addr,
  output out_word_u                               rd_data,
  output logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0] sample_count,
  output logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0] tstamp_count,
  output logic         [`SSB_CHANNELS-1:0]        chan_full
);

  localparam int CH           = `SSB_CHANNELS;
  localparam int DATA_DEPTH   = `SSB_DATA_DEPTH;
  localparam int TSTAMP_DEPTH = `SSB_TSTAMP_DEPTH;
  localparam int INDEX_W      = `SSB_INDEX_W;
  localparam int TS_AW        = `SSB_TSTAMP_AW;
  localparam int COUNT_W      = `SSB_COUNT_W;

  sample_word_t smem [CH][DATA_DEPTH];
  tstamp_word_t tmem [CH][TSTAMP_DEPTH];

  // time of the input cycle, one behind the timer like the write requests
  logic [`SSB_TIME_W-1:0] time_d;
  logic         [CH-1:0]  do_wr;
  tstamp_word_t [CH-1:0]  ts_entry;

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      chan_full[c] = (sample_count[c] == COUNT_W'(DATA_DEPTH)) ||
                     (tstamp_count[c] == COUNT_W'(TSTAMP_DEPTH));
      do_wr[c] = wr_en[c] && !chan_full[c];
      ts_entry[c].index = sample_count[c][INDEX_W-1:0];
      ts_entry[c].stamp_time = time_d;
    end
  end

  ////////////////////
  // write pointers
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sample_count <= '0;
      tstamp_count <= '0;
    end else begin
      for (int c = 0; c < CH; c++) begin
        if (do_wr[c]) begin
          sample_count[c] <= sample_count[c] + 1'b1;
          if (run_start[c]) tstamp_count[c] <= tstamp_count[c] + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // memories
  always_ff @(posedge clk) begin
    time_d <= cap_time;
    for (int c = 0; c < CH; c++) begin
      if (do_wr[c]) begin
        smem[c][sample_count[c][INDEX_W-1:0]] <= wr_data[c];
        if (run_start[c]) tmem[c][tstamp_count[c][TS_AW-1:0]] <= ts_entry[c];
      end
    end
    if (rd_is_tstamp) begin
      rd_data.tstamp <= tmem[rd_chan][rd_addr[TS_AW-1:0]];
    end else begin
      rd_data.samples <= smem[rd_chan][rd_addr];
    end
  end

  // once full, neither pointer of the channel moves until the next clear
  for (genvar c = 0; c < CH; c++) begin : g_full_check
    assert property (@(posedge clk) disable iff (reset)
      chan_full[c] && !clear |=> $stable(sample_count[c]) && $stable(tstamp_count[c]));
  end

endmodule

/* source/readout_fsm.sv */
/*
  capture control and stream readout
  per channel: timestamp header, timestamps, sample header, samples
  rd_* carry the next address, so rd_data always matches the current position
  the address only moves when the output register is free
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module readout_fsm import ssb_stream_pkg::*; (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      capture_start,
  input  logic                                      capture_stop,
  input  logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0] sample_count,
  input  logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0] tstamp_count,
  input  out_word_u                                 rd_data,
  input  logic                                      out_ready,
  output logic                                      capturing,
  output logic                                      store_clear,
  output logic [`SSB_CHAN_W-1:0]                    rd_chan,
  output logic                                      rd_is_tstamp,
  output logic [`SSB_INDEX_W-1:0]                   rd_addr,
  output logic                                      out_valid,
  output out_beat_t                                 out_beat
);

  localparam int CHAN_W  = `SSB_CHAN_W;
  localparam int COUNT_W = `SSB_COUNT_W;
  localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(`SSB_CHANNELS - 1);

  ro_state_e                  state, state_n;
  logic [CHAN_W-1:0]          chan, chan_n;
  logic [`SSB_INDEX_W-1:0]    idx, idx_n;
  logic [COUNT_W-1:0]         cnt_ts, cnt_smp;
  logic                       slot_free, load, last_chan, ts_end, smp_end;
  out_beat_t                  beat_n;

  function automatic out_word_u make_hdr(input logic [CHAN_W-1:0] ch, input logic is_smp,
                                         input logic [COUNT_W-1:0] cnt);
    hdr_word_t h;
    out_word_u w;
    h = '0;
    h.channel = ch;
    h.is_sample_section = is_smp;
    h.count = cnt;
    w.hdr = h;
    return w;
  endfunction

  assign cnt_ts    = tstamp_count[chan];
  assign cnt_smp   = sample_count[chan];
  assign last_chan = (chan == LAST_CHAN);
  assign ts_end    = (COUNT_W'(idx) == cnt_ts - 1'b1);
  assign smp_end   = (COUNT_W'(idx) == cnt_smp - 1'b1);
  // output register can take a new beat
  assign slot_free = !out_valid || out_ready;

  ////////////////////
  // next state
  always_comb begin
    state_n = state;
    chan_n = chan;
    idx_n = idx;
    load = 1'b0;
    beat_n = '0;
    case (state)
      RO_IDLE: if (capture_start) state_n = RO_CAPTURE;
      RO_CAPTURE: if (capture_stop) state_n = RO_DRAIN;
      // one cycle for the final write to land in the store
      RO_DRAIN: begin
        state_n = RO_TS_HDR;
        chan_n = '0;
      end
      RO_TS_HDR: if (slot_free) begin
        load = 1'b1;
        beat_n.word = make_hdr(chan, 1'b0, cnt_ts);
        idx_n = '0;
        state_n = (cnt_ts != '0) ? RO_TS_DATA : RO_SMP_HDR;
      end
      RO_TS_DATA: if (slot_free) begin
        load = 1'b1;
        beat_n.word = rd_data;
        idx_n = idx + 1'b1;
        if (ts_end) begin
          idx_n = '0;
          state_n = RO_SMP_HDR;
        end
      end
      RO_SMP_HDR: if (slot_free) begin
        load = 1'b1;
        beat_n.word = make_hdr(chan, 1'b1, cnt_smp);
        idx_n = '0;
        if (cnt_smp != '0) begin
          state_n = RO_SMP_DATA;
        end else begin
          // empty sample section closes the channel here
          beat_n.last = last_chan;
          chan_n = chan + 1'b1;
          state_n = last_chan ? RO_IDLE : RO_TS_HDR;
        end
      end
      RO_SMP_DATA: if (slot_free) begin
        load = 1'b1;
        beat_n.word = rd_data;
        idx_n = idx + 1'b1;
        if (smp_end) begin
          beat_n.last = last_chan;
          idx_n = '0;
          chan_n = chan + 1'b1;
          state_n = last_chan ? RO_IDLE : RO_TS_HDR;
        end
      end
      default: state_n = RO_IDLE;
    endcase
  end

  // prefetch address for the position held next cycle
  assign rd_chan      = chan_n;
  assign rd_is_tstamp = (state_n == RO_TS_DATA);
  assign rd_addr      = idx_n;
  assign capturing    = (state == RO_CAPTURE);

  ////////////////////
  // registers
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RO_IDLE;
      chan <= '0;
      idx <= '0;
      out_valid <= 1'b0;
      store_clear <= 1'b0;
    end else begin
      state <= state_n;
      chan <= chan_n;
      idx <= idx_n;
      store_clear <= (state == RO_IDLE) && capture_start;
      if (slot_free) out_valid <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) out_beat <= beat_n;
  end

  // a stalled beat stays put until it transfers
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* source/sparse_sample_buffer.sv */
/*
  sparse sample buffer top
  thresholds load on cfg_valid, capture runs from capture_start to capture_stop
  the buffered data then streams out once per capture with valid/ready
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module sparse_sample_buffer import ssb_cfg_pkg::*, ssb_stream_pkg::*; (
  input  logic                                clk,
  input  logic                                reset,
  input  logic         [`SSB_CHANNELS-1:0]    in_valid,
  input  sample_word_t [`SSB_CHANNELS-1:0]    in_data,
  input  logic                                cfg_valid,
  input  threshold_t   [`SSB_CHANNELS-1:0]    cfg_thresholds,
  input  logic                                capture_start,
  input  logic                                capture_stop,
  input  logic                                out_ready,
  output logic                                out_valid,
  output out_beat_t                           out_beat
);

  logic                                        capturing;
  logic                                        store_clear;
  logic         [`SSB_CHANNELS-1:0]            wr_en;
  sample_word_t [`SSB_CHANNELS-1:0]            wr_data;
  logic         [`SSB_CHANNELS-1:0]            run_start;
  logic         [`SSB_CHANNELS-1:0]            chan_full;
  logic         [`SSB_TIME_W-1:0]              cap_time;
  logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0]  sample_count;
  logic [`SSB_CHANNELS-1:0][`SSB_COUNT_W-1:0]  tstamp_count;
  out_word_u                                   rd_data;
  logic         [`SSB_CHAN_W-1:0]              rd_chan;
  logic                                        rd_is_tstamp;
  logic         [`SSB_INDEX_W-1:0]             rd_addr;

  sample_discriminator u_disc (
    .clk            (clk),
    .reset          (reset),
    .capturing      (capturing),
    .cfg_valid      (cfg_valid),
    .cfg_thresholds (cfg_thresholds),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .chan_full      (chan_full),
    .wr_en          (wr_en),
    .wr_data        (wr_data),
    .run_start      (run_start)
  );

  capture_timer u_timer (
    .clk      (clk),
    .reset    (reset),
    .clear    (store_clear),
    .run      (capturing),
    .cap_time (cap_time)
  );

  sample_store u_store (
    .clk          (clk),
    .reset        (reset),
    .clear        (store_clear),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .run_start    (run_start),
    .cap_time     (cap_time),
    .rd_chan      (rd_chan),
    .rd_is_tstamp (rd_is_tstamp),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .sample_count (sample_count),
    .tstamp_count (tstamp_count),
    .chan_full    (chan_full)
  );

  readout_fsm u_fsm (
    .clk           (clk),
    .reset         (reset),
    .capture_start (capture_start),
    .capture_stop  (capture_stop),
    .sample_count  (sample_count),
    .tstamp_count  (tstamp_count),
    .rd_data       (rd_data),
    .out_ready     (out_ready),
    .capturing     (capturing),
    .store_clear   (store_clear),
    .rd_chan       (rd_chan),
    .rd_is_tstamp  (rd_is_tstamp),
    .rd_addr       (rd_addr),
    .out_valid     (out_valid),
    .out_beat      (out_beat)
  );

endmodule

/* dv/tb_clock.sv */
/*
  free running testbench clock, starts low
*/
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

/* dv/sparse_sample_buffer_tb.sv */
/*
  random capture trials checked against a model of discriminator, store and stream order
  each trial runs twice on the same stimulus, first with out_ready high, then random
  no input word is sent in the first capture cycle after capture_start
*/
`include "ssb_consts.svh"
`timescale 1ns/1ns

module sparse_sample_buffer_tb import ssb_cfg_pkg::*, ssb_stream_pkg::*; ();

  localparam int CH        = `SSB_CHANNELS;
  localparam int PS        = `SSB_PAR_SAMPLES;
  localparam int MAX_WORDS = 120;
  localparam int TRIALS    = 12;
  localparam int TIMEOUT   = 5000;
  localparam int KIND_HDR  = 0;
  localparam int KIND_TS   = 1;
  localparam int KIND_SMP  = 2;

  logic                   clk;
  logic                   reset;
  logic         [CH-1:0]  in_valid;
  sample_word_t [CH-1:0]  in_data;
  logic                   cfg_valid;
  threshold_t   [CH-1:0]  cfg_thresholds;
  logic                   capture_start;
  logic                   capture_stop;
  logic                   out_ready;
  logic                   out_valid;
  out_beat_t              out_beat;

  integer seed = 32'hab52e2ca;

  // one trial's stimulus, replayed for the second run
  threshold_t   [CH-1:0]  stim_thr;
  logic         [CH-1:0]  stim_valid [MAX_WORDS];
  sample_word_t [CH-1:0]  stim_data [MAX_WORDS];
  int                     n_words;

  out_beat_t exp_q[$];
  int        kind_q[$];
  out_beat_t got_q[$];

  tb_clock clock_gen (.clk(clk));

  sparse_sample_buffer dut (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .cfg_valid      (cfg_valid),
    .cfg_thresholds (cfg_thresholds),
    .capture_start  (capture_start),
    .capture_stop   (capture_stop),
    .out_ready      (out_ready),
    .out_valid      (out_valid),
    .out_beat       (out_beat)
  );

  ////////////////////
  // error reporting and compares
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_header(input string name, input hdr_word_t got, input hdr_word_t want);
    if (got !== want) stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  task automatic check_tstamp(input string name, input tstamp_word_t got,
                              input tstamp_word_t want);
    if (got !== want) stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  task automatic check_samples(input string name, input sample_word_t got,
                               input sample_word_t want);
    if (got !== want) stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  task automatic check_last(input string name, input logic got, input logic want);
    if (got !== want) stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  ////////////////////
  // stimulus
  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // quiet, anywhere, or loud
  function automatic logic [`SSB_SAMPLE_W-1:0] rand_sample(input int mode);
    case (mode)
      0: return `SSB_SAMPLE_W'(rand_below(32'h1000));
      1: return `SSB_SAMPLE_W'(rand_below(32'h10000));
      default: return `SSB_SAMPLE_W'(32'hc000 + rand_below(32'h4000));
    endcase
  endfunction

  task automatic gen_stimulus(input bit long_run);
    int mode;
    n_words = long_run ? MAX_WORDS : 20 + int'(rand_below(101));
    for (int c = 0; c < CH; c++) begin
      case (rand_below(3))
        0: stim_thr[c] = '0;  // keep all
        1: stim_thr[c] = '1;  // keep none
        default: begin
          // straddling pair, words between low and high extend a run
          stim_thr[c].high = `SSB_SAMPLE_W'(32'h8000 + rand_below(32'h6000));
          stim_thr[c].low = `SSB_SAMPLE_W'(32'h1000 + rand_below(32'h6000));
        end
      endcase
    end
    // a long keep-all channel runs past the sample depth
    if (long_run) stim_thr[0] = '0;
    for (int w = 0; w < n_words; w++) begin
      for (int c = 0; c < CH; c++) begin
        stim_valid[w][c] = (rand_below(4) != 0);
        mode = int'(rand_below(3));
        for (int s = 0; s < PS; s++) stim_data[w][c][s] = rand_sample(mode);
      end
    end
  endtask

  ////////////////////
  // reference model
  task automatic add_beat(input out_word_u wd, input int kind);
    out_beat_t b;
    b = '0;
    b.word = wd;
    exp_q.push_back(b);
    kind_q.push_back(kind);
  endtask

  task automatic build_expected();
    sample_word_t kept[$];
    tstamp_word_t runs[$];
    tstamp_word_t t;
    hdr_word_t    h;
    out_word_u    wd;
    out_beat_t    b;
    logic         armed, prev_kept, any_high, all_low, keep;
    exp_q.delete();
    kind_q.delete();
    for (int c = 0; c < CH; c++) begin
      kept.delete();
      runs.delete();
      armed = 1'b0;
      prev_kept = 1'b0;
      for (int w = 0; w < n_words; w++) begin
        if (stim_valid[w][c]) begin
          any_high = 1'b0;
          all_low = 1'b1;
          for (int s = 0; s < PS; s++) begin
            if (stim_data[w][c][s] > stim_thr[c].high) any_high = 1'b1;
            if (stim_data[w][c][s] >= stim_thr[c].low) all_low = 1'b0;
          end
          keep = any_high || (armed && !all_low);
          if (any_high) begin
            armed = 1'b1;
          end else if (all_low) begin
            armed = 1'b0;
          end
          // a full channel drops the word and any timestamp with it
          if (keep && kept.size() < `SSB_DATA_DEPTH && runs.size() < `SSB_TSTAMP_DEPTH) begin
            if (!prev_kept) begin
              t.index = `SSB_INDEX_W'(kept.size());
              // word w sits w+2 cycles after the start pulse, time 0 is start+1
              t.stamp_time = `SSB_TIME_W'(w + 1);
              runs.push_back(t);
            end
            kept.push_back(stim_data[w][c]);
          end
          prev_kept = keep;
        end
      end
      h = '0;
      h.channel = `SSB_CHAN_W'(c);
      h.count = `SSB_COUNT_W'(runs.size());
      wd.hdr = h;
      add_beat(wd, KIND_HDR);
      foreach (runs[i]) begin
        wd.tstamp = runs[i];
        add_beat(wd, KIND_TS);
      end
      h.is_sample_section = 1'b1;
      h.count = `SSB_COUNT_W'(kept.size());
      wd.hdr = h;
      add_beat(wd, KIND_HDR);
      foreach (kept[i]) begin
        wd.samples = kept[i];
        add_beat(wd, KIND_SMP);
      end
    end
    b = exp_q.pop_back();
    b.last = 1'b1;
    exp_q.push_back(b);
  endtask

  ////////////////////
  // drive and collect
  task automatic step_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic collect_stream(input bit random_ready);
    int waited;
    bit done;
    got_q.delete();
    waited = 0;
    done = 1'b0;
    while (!done) begin
      step_cycle();
      out_ready = random_ready ? (rand_below(3) != 0) : 1'b1;
      if (out_valid && out_ready) begin
        // transfers at the coming edge
        got_q.push_back(out_beat);
        done = out_beat.last;
        waited = 0;
        if (got_q.size() > exp_q.size()) stop_on_error("stream runs past the expected length");
      end else begin
        waited++;
        if (waited >= TIMEOUT) stop_on_error("timed out waiting for the next stream beat");
      end
    end
    step_cycle();
    out_ready = 1'b0;
    if (out_valid) stop_on_error("out_valid still high after the last beat");
  endtask

  task automatic run_capture(input bit random_ready);
    step_cycle();
    cfg_valid = 1'b1;
    cfg_thresholds = stim_thr;
    step_cycle();
    cfg_valid = 1'b0;
    capture_start = 1'b1;
    step_cycle();
    capture_start = 1'b0;
    for (int w = 0; w < n_words; w++) begin
      step_cycle();
      in_valid = stim_valid[w];
      in_data = stim_data[w];
      // the word sent with stop is still captured
      capture_stop = (w == n_words - 1);
    end
    step_cycle();
    in_valid = '0;
    capture_stop = 1'b0;
    collect_stream(random_ready);
  endtask

  task automatic compare_stream();
    out_beat_t got;
    out_beat_t want;
    if (got_q.size() != exp_q.size()) begin
      stop_on_error($sformatf("stream has %0d beats where %0d were expected",
                              got_q.size(), exp_q.size()));
    end
    for (int i = 0; i < exp_q.size(); i++) begin
      got = got_q[i];
      want = exp_q[i];
      case (kind_q[i])
        KIND_HDR: check_header($sformatf("out_beat.word.hdr[%0d]", i), got.word.hdr,
                               want.word.hdr);
        KIND_TS: check_tstamp($sformatf("out_beat.word.tstamp[%0d]", i), got.word.tstamp,
                              want.word.tstamp);
        default: check_samples($sformatf("out_beat.word.samples[%0d]", i), got.word.samples,
                               want.word.samples);
      endcase
      check_last($sformatf("out_beat.last[%0d]", i), got.last, want.last);
    end
  endtask

  ////////////////////
  // main sequence
  initial begin
    reset = 1'b1;
    in_valid = '0;
    in_data = '0;
    cfg_valid = 1'b0;
    cfg_thresholds = '0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    for (int t = 0; t < TRIALS; t++) begin
      gen_stimulus(t == TRIALS - 1);
      build_expected();
      run_capture(1'b0);
      compare_stream();
      // same stimulus under back-pressure
      run_capture(1'b1);
      compare_stream();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* sparse_sample_buffer.f */
+incdir+source
source/ssb_cfg_pkg.sv
source/ssb_stream_pkg.sv
source/sample_discriminator.sv
source/capture_timer.sv
source/sample_store.sv
source/readout_fsm.sv
source/sparse_sample_buffer.sv
dv/tb_clock.sv
dv/sparse_sample_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sparse_sample_buffer.f --top-module sparse_sample_buffer_tb \
  -o sparse_sample_buffer_sim > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sparse_sample_buffer_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
